//--- logic/cpu_isa_pkg.sv
// ----------------------------------------------------------------------------
// Instruction set definitions for the 16-bit pipelined core: word and
// register types, opcode and ALU encodings, and instruction field positions.
// Imported by every pipeline stage and by the testbench model.
// ----------------------------------------------------------------------------
package cpu_isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // Major opcodes in bits 15:11
   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      ADDI  = 5'b01000,
      BEQZ  = 5'b01100,
      ST    = 5'b10000,
      LD    = 5'b10001,
      RTYPE = 5'b11011
   } opcode_t;

   // R-format function field
   // SUB gives rs minus rt
   typedef enum logic [1:0] {
      ADD = 2'b00,
      SUB = 2'b01,
      XOR = 2'b10,
      AND = 2'b11
   } alu_op_t;

   // Field positions
   localparam int OPC_HI  = 15;
   localparam int OPC_LO  = 11;
   localparam int RS_HI   = 10;
   localparam int RS_LO   = 8;
   localparam int RT_HI   = 7;
   localparam int RT_LO   = 5;
   localparam int RD_HI   = 4;
   localparam int RD_LO   = 2;
   localparam int FN_HI   = 1;
   localparam int FN_LO   = 0;
   localparam int IMM5_HI = 4;
   localparam int IMM8_HI = 7;

   function automatic word_t sext_imm5(input word_t instr);
      return {{11{instr[IMM5_HI]}}, instr[IMM5_HI:0]};
   endfunction

   function automatic word_t sext_imm8(input word_t instr);
      return {{8{instr[IMM8_HI]}}, instr[IMM8_HI:0]};
   endfunction

endpackage

//--- logic/cpu_pipe_pkg.sv
// ----------------------------------------------------------------------------
// Stage-to-stage records of the five-stage pipeline and the write-back
// trace. An all-zero record is an invalid entry, which pipe_reg relies on
// when it flushes or resets.
// ----------------------------------------------------------------------------
package cpu_pipe_pkg;

   // Fetch to decode
   typedef struct packed {
      logic               valid;
      cpu_isa_pkg::word_t instr;
      cpu_isa_pkg::word_t pc_inc;
   } if_id_t;

   // Decode to execute
   typedef struct packed {
      logic                  valid;
      cpu_isa_pkg::reg_idx_t rs;
      cpu_isa_pkg::reg_idx_t rt;
      cpu_isa_pkg::word_t    rs_val;
      cpu_isa_pkg::word_t    rt_val;
      cpu_isa_pkg::word_t    imm;
      cpu_isa_pkg::alu_op_t  alu_op;
      logic                  use_imm;
      logic                  uses_rt;
      logic                  mem_rd;
      logic                  mem_wr;
      logic                  reg_wr;
      logic                  is_branch;
      logic                  is_halt;
      cpu_isa_pkg::reg_idx_t dest;
      cpu_isa_pkg::word_t    pc_inc;
   } id_ex_t;

   // Execute to memory
   typedef struct packed {
      logic                  valid;
      cpu_isa_pkg::word_t    alu_res;
      cpu_isa_pkg::word_t    st_data;
      logic                  mem_rd;
      logic                  mem_wr;
      logic                  reg_wr;
      cpu_isa_pkg::reg_idx_t dest;
      logic                  is_halt;
   } ex_mem_t;

   // Memory to write-back
   typedef struct packed {
      logic                  valid;
      logic                  reg_wr;
      cpu_isa_pkg::reg_idx_t dest;
      cpu_isa_pkg::word_t    wb_val;
      logic                  is_halt;
   } mem_wb_t;

   typedef struct packed {
      cpu_isa_pkg::reg_idx_t dest;
      cpu_isa_pkg::word_t    value;
   } wb_trace_t;

endpackage

//--- logic/pipe_reg.sv
// ----------------------------------------------------------------------------
// Pipeline register for any stage record. Flush wins over hold and
// loads an all-zero, invalid entry.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     hold,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q <= '0;
      end else if (flush) begin
         q <= '0;
      end else if (!hold) begin
         q <= d;
      end
   end

endmodule

//--- logic/fetch_stage.sv
// ----------------------------------------------------------------------------
// Fetch stage. Holds the PC, presents it as the instruction memory word
// address and packs the returned instruction with PC+1 for decode.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module fetch_stage #(
   parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 stall,
   input  logic                 redirect,
   input  cpu_isa_pkg::word_t   redirect_pc,
   input  logic                 stop,
   input  cpu_isa_pkg::word_t   imem_data,
   output cpu_isa_pkg::word_t   imem_addr,
   output cpu_pipe_pkg::if_id_t fetched
);

   import cpu_isa_pkg::*;

   word_t pc;
   word_t pc_inc;

   assign pc_inc    = pc + 16'd1;
   assign imem_addr = pc;

   // Taken branch beats both stall and halt
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc <= RESET_PC;
      end else if (redirect) begin
         pc <= redirect_pc;
      end else if (!stall && !stop) begin
         pc <= pc_inc;
      end
   end

   // Nothing valid leaves fetch once a HALT is on its way
   always_comb begin
      fetched.valid  = !stop;
      fetched.instr  = imem_data;
      fetched.pc_inc = pc_inc;
   end

endmodule

//--- logic/decode_stage.sv
// ----------------------------------------------------------------------------
// Decode stage with the 8 x 16-bit register file. Produces the control
// record for execute, detects load-use hazards, freezes fetch on HALT and
// flags undefined opcodes on a sticky err.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module decode_stage (
   input  logic                 clk,
   input  logic                 arst_n,
   input  cpu_pipe_pkg::if_id_t in,
   input  cpu_pipe_pkg::id_ex_t ex_entry,
   input  cpu_pipe_pkg::mem_wb_t wb,
   output cpu_pipe_pkg::id_ex_t out,
   output logic                 stall,
   output logic                 stop,
   output logic                 err
);

   import cpu_isa_pkg::*;

   word_t    rf [8];
   opcode_t  opc;
   reg_idx_t rs;
   reg_idx_t rt;
   logic     wb_we;
   logic     uses_rs;
   logic     illegal;
   logic     halt_seen;

   assign opc   = opcode_t'(in.instr[OPC_HI:OPC_LO]);
   assign rs    = in.instr[RS_HI:RS_LO];
   assign rt    = in.instr[RT_HI:RT_LO];
   assign wb_we = wb.valid && wb.reg_wr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 8; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_we) begin
         rf[wb.dest] <= wb.wb_val;
      end
   end

   always_comb begin
      out     = '0;
      illegal = 1'b0;
      uses_rs = 1'b0;
      out.rs  = rs;
      out.rt  = rt;
      // Write-through so a same-cycle write-back is seen here
      out.rs_val = (wb_we && wb.dest == rs) ? wb.wb_val : rf[rs];
      out.rt_val = (wb_we && wb.dest == rt) ? wb.wb_val : rf[rt];
      out.dest   = rt;
      out.pc_inc = in.pc_inc;
      out.alu_op = ADD;
      case (opc)
         HALT: out.is_halt = 1'b1;
         NOP: ;
         ADDI: begin
            uses_rs     = 1'b1;
            out.use_imm = 1'b1;
            out.reg_wr  = 1'b1;
            out.imm     = sext_imm5(in.instr);
         end
         RTYPE: begin
            uses_rs     = 1'b1;
            out.uses_rt = 1'b1;
            out.reg_wr  = 1'b1;
            out.dest    = in.instr[RD_HI:RD_LO];
            out.alu_op  = alu_op_t'(in.instr[FN_HI:FN_LO]);
         end
         LD: begin
            uses_rs     = 1'b1;
            out.use_imm = 1'b1;
            out.mem_rd  = 1'b1;
            out.reg_wr  = 1'b1;
            out.imm     = sext_imm5(in.instr);
         end
         ST: begin
            uses_rs     = 1'b1;
            out.uses_rt = 1'b1;
            out.use_imm = 1'b1;
            out.mem_wr  = 1'b1;
            out.imm     = sext_imm5(in.instr);
         end
         BEQZ: begin
            uses_rs       = 1'b1;
            out.is_branch = 1'b1;
            out.imm       = sext_imm8(in.instr);
         end
         default: illegal = 1'b1;
      endcase
      out.valid = in.valid && !illegal;
   end

   // Loaded value is not ready until the load leaves memory
   assign stall = in.valid && ex_entry.valid && ex_entry.mem_rd &&
                  ((uses_rs && ex_entry.dest == rs) ||
                   (out.uses_rt && ex_entry.dest == rt));

   // HALT in decode, then in execute, then latched for good
   assign stop = (in.valid && opc == HALT) ||
                 (ex_entry.valid && ex_entry.is_halt) || halt_seen;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_seen <= 1'b0;
         err       <= 1'b0;
      end else begin
         halt_seen <= halt_seen || (ex_entry.valid && ex_entry.is_halt);
         err       <= err || (in.valid && illegal);
      end
   end

endmodule

//--- logic/execute_stage.sv
// ----------------------------------------------------------------------------
// Execute stage. Picks operands from EX/MEM, MEM/WB or the decode read,
// runs the ALU and resolves BEQZ. A taken branch drives redirect and its
// target for one cycle; the core flushes the two younger entries.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module execute_stage (
   input  cpu_pipe_pkg::id_ex_t  in,
   input  cpu_pipe_pkg::ex_mem_t fwd_mem,
   input  cpu_pipe_pkg::mem_wb_t fwd_wb,
   output cpu_pipe_pkg::ex_mem_t out,
   output logic                  redirect,
   output cpu_isa_pkg::word_t    redirect_pc
);

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t op_a;
   word_t op_b;
   word_t alu_b;
   word_t alu_res;

   // Youngest producer wins; loads in EX/MEM have no value yet
   function automatic word_t fwd_pick(
      input ex_mem_t  m,
      input mem_wb_t  w,
      input reg_idx_t idx,
      input word_t    dec_val
   );
      if (m.valid && m.reg_wr && !m.mem_rd && m.dest == idx) begin
         return m.alu_res;
      end else if (w.valid && w.reg_wr && w.dest == idx) begin
         return w.wb_val;
      end
      return dec_val;
   endfunction

   assign op_a = fwd_pick(fwd_mem, fwd_wb, in.rs, in.rs_val);
   assign op_b = in.uses_rt ? fwd_pick(fwd_mem, fwd_wb, in.rt, in.rt_val) : in.rt_val;

   // Loads and stores arrive here as ADD with the immediate
   always_comb begin
      alu_b   = in.use_imm ? in.imm : op_b;
      alu_res = op_a + alu_b;
      case (in.alu_op)
         ADD: alu_res = op_a + alu_b;
         SUB: alu_res = op_a - alu_b;
         XOR: alu_res = op_a ^ alu_b;
         AND: alu_res = op_a & alu_b;
      endcase
   end

   assign redirect    = in.valid && in.is_branch && (op_a == '0);
   assign redirect_pc = in.pc_inc + in.imm;

   always_comb begin
      out.valid   = in.valid;
      out.alu_res = alu_res;
      out.st_data = op_b;
      out.mem_rd  = in.mem_rd;
      out.mem_wr  = in.mem_wr;
      out.reg_wr  = in.reg_wr;
      out.dest    = in.dest;
      out.is_halt = in.is_halt;
   end

endmodule

//--- logic/memory_stage.sv
// ----------------------------------------------------------------------------
// Memory stage with the data memory. Stores write on the clock edge,
// loads read combinationally, and the write-back value is chosen here.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module memory_stage #(
   parameter int DMEM_DEPTH = 64
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  cpu_pipe_pkg::ex_mem_t in,
   output cpu_pipe_pkg::mem_wb_t out
);

   import cpu_isa_pkg::*;

   localparam int AW = $clog2(DMEM_DEPTH);

   word_t         dmem [DMEM_DEPTH];
   logic [AW-1:0] addr;

   // Word address wraps at the memory depth
   assign addr = AW'(32'(in.alu_res) % DMEM_DEPTH);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (in.valid && in.mem_wr) begin
         dmem[addr] <= in.st_data;
      end
   end

   always_comb begin
      out.valid   = in.valid;
      out.reg_wr  = in.reg_wr;
      out.dest    = in.dest;
      out.wb_val  = in.mem_rd ? dmem[addr] : in.alu_res;
      out.is_halt = in.is_halt;
   end

endmodule

//--- logic/cpu_core.sv
// ----------------------------------------------------------------------------
// Top of the five-stage core. Links fetch, decode, execute and memory
// through four pipeline registers and routes stall, redirect and halt.
// Instruction memory is external; write-backs appear on the trace port.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module cpu_core #(
   parameter cpu_isa_pkg::word_t RESET_PC   = '0,
   parameter int                 DMEM_DEPTH = 64
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  cpu_isa_pkg::word_t      imem_data,
   output cpu_isa_pkg::word_t      imem_addr,
   output logic                    wb_valid,
   output cpu_pipe_pkg::wb_trace_t wb_trace,
   output logic                    halted,
   output logic                    err
);

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   if_id_t  if_d,  if_q;
   id_ex_t  id_d,  id_q;
   ex_mem_t ex_d,  ex_q;
   mem_wb_t mem_d, mem_q;
   logic    stall;
   logic    stop;
   logic    redirect;
   word_t   redirect_pc;

   fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
      .clk, .arst_n, .stall, .redirect, .redirect_pc, .stop,
      .imem_data, .imem_addr, .fetched(if_d)
   );

   pipe_reg #(.payload_t(if_id_t)) if_id_i (
      .clk, .arst_n, .hold(stall), .flush(redirect), .d(if_d), .q(if_q)
   );

   decode_stage decode_i (
      .clk, .arst_n, .in(if_q), .ex_entry(id_q), .wb(mem_q),
      .out(id_d), .stall, .stop, .err
   );

   // Stall leaves a bubble behind the load
   pipe_reg #(.payload_t(id_ex_t)) id_ex_i (
      .clk, .arst_n, .hold(1'b0), .flush(redirect || stall), .d(id_d), .q(id_q)
   );

   execute_stage execute_i (
      .in(id_q), .fwd_mem(ex_q), .fwd_wb(mem_q),
      .out(ex_d), .redirect, .redirect_pc
   );

   pipe_reg #(.payload_t(ex_mem_t)) ex_mem_i (
      .clk, .arst_n, .hold(1'b0), .flush(1'b0), .d(ex_d), .q(ex_q)
   );

   memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) memory_i (
      .clk, .arst_n, .in(ex_q), .out(mem_d)
   );

   pipe_reg #(.payload_t(mem_wb_t)) mem_wb_i (
      .clk, .arst_n, .hold(1'b0), .flush(1'b0), .d(mem_d), .q(mem_q)
   );

   assign wb_valid       = mem_q.valid && mem_q.reg_wr;
   assign wb_trace.dest  = mem_q.dest;
   assign wb_trace.value = mem_q.wb_val;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
      end else if (mem_q.valid && mem_q.is_halt) begin
         halted <= 1'b1;
      end
   end

endmodule

//--- sim/cpu_core_properties.sv
// ----------------------------------------------------------------------------
// Concurrent checks on the status and trace outputs of the core, bound
// into every cpu_core instance.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module cpu_core_properties (
   input logic               clk,
   input logic               arst_n,
   input logic               wb_valid,
   input logic               halted,
   input logic               err,
   input cpu_isa_pkg::word_t imem_addr
);

   // Sticky outputs clear only through reset
   err_sticky: assert property (@(posedge clk) disable iff (!arst_n) err |=> err)
      else $error("err fell while out of reset");

   halted_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
      else $error("halted fell while out of reset");

   no_wb_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_valid)
      else $error("wb_valid high during reset");

   // Fetch is frozen once the core halts
   pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
                               $rose(halted) |=> $stable(imem_addr))
      else $error("imem_addr moved after halted rose");

endmodule

bind cpu_core cpu_core_properties props_i (
   .clk, .arst_n, .wb_valid, .halted, .err, .imem_addr
);

//--- sim/cpu_core_tb.sv
// ----------------------------------------------------------------------------
// Directed testbench for the five-stage core. Each test loads a short
// program into the instruction memory model, resets the DUT, runs to halt
// and compares the write-back trace with an instruction-level model.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module cpu_core_tb;

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   localparam word_t RESET_PC   = 16'h0000;
   localparam int    DMEM_DEPTH = 64;
   localparam int    DMEM_AW    = $clog2(DMEM_DEPTH);
   localparam int    NUM_TESTS  = 5;
   localparam int    HALT_LIMIT = 100;
   localparam real   CLK_PERIOD = 40.0;

   logic      clk;
   logic      arst_n;
   word_t     imem_data;
   word_t     imem_addr;
   logic      wb_valid;
   wb_trace_t wb_trace;
   logic      halted;
   logic      err;

   word_t     imem [64];
   word_t     model_rf [8];
   word_t     model_mem [DMEM_DEPTH];
   wb_trace_t trace_q [$];
   wb_trace_t exp_q [$];
   integer    seed;
   int        errors;
   int        checks;

   cpu_core #(.RESET_PC(RESET_PC), .DMEM_DEPTH(DMEM_DEPTH)) dut_i (
      .clk, .arst_n, .imem_data, .imem_addr, .wb_valid, .wb_trace, .halted, .err
   );

   assign imem_data = imem[imem_addr[5:0]];

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      if (wb_valid) begin
         trace_q.push_back(wb_trace);
      end
   end

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

   function automatic word_t encode_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t encode_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, alu_op_t fn);
      return {RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic word_t encode_b(reg_idx_t rs, logic [7:0] off);
      return {BEQZ, rs, off};
   endfunction

   // HALT words with their own address in the low bits
   task automatic fill_imem();
      int i;
      for (i = 0; i < 64; i++) begin
         imem[i] = {10'b0, 6'(i)};
      end
   endtask

   task automatic check_trace(input int idx, input wb_trace_t got, input wb_trace_t exp);
      checks++;
      if (got.dest !== exp.dest) begin
         $display("CHECK FAILED wb_trace.dest #%0d: got %h, expected %h", idx, got.dest, exp.dest);
         errors++;
      end
      if (got.value !== exp.value) begin
         $display("CHECK FAILED wb_trace.value #%0d: got %h, expected %h",
                  idx, got.value, exp.value);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic model_write(input reg_idx_t dest, input word_t value);
      wb_trace_t t;
      model_rf[dest] = value;
      t.dest  = dest;
      t.value = value;
      exp_q.push_back(t);
   endtask

   // One instruction per step, straight from the ISA rules
   task automatic model_program();
      word_t              pc;
      word_t              ins;
      word_t              a;
      word_t              b;
      word_t              imm5;
      word_t              res;
      logic [DMEM_AW-1:0] ea;
      logic               done;
      int                 i;
      exp_q.delete();
      for (i = 0; i < 8; i++) begin
         model_rf[i] = '0;
      end
      for (i = 0; i < DMEM_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      pc   = RESET_PC;
      done = 1'b0;
      for (i = 0; i < 64 && !done; i++) begin
         ins  = imem[pc[5:0]];
         a    = model_rf[ins[10:8]];
         b    = model_rf[ins[7:5]];
         imm5 = {{11{ins[4]}}, ins[4:0]};
         ea   = DMEM_AW'(int'(word_t'(a + imm5)) % DMEM_DEPTH);
         pc   = pc + 16'd1;
         case (opcode_t'(ins[15:11]))
            HALT: done = 1'b1;
            ADDI: model_write(ins[7:5], a + imm5);
            LD: model_write(ins[7:5], model_mem[ea]);
            ST: model_mem[ea] = b;
            BEQZ: begin
               if (a == '0) begin
                  pc = pc + {{8{ins[7]}}, ins[7:0]};
               end
            end
            RTYPE: begin
               case (alu_op_t'(ins[1:0]))
                  ADD: res = a + b;
                  SUB: res = a - b;
                  XOR: res = a ^ b;
                  AND: res = a & b;
               endcase
               model_write(ins[4:2], res);
            end
            default: ;
         endcase
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      arst_n <= 1'b0;
      repeat (2) @(posedge clk);
      trace_q.delete();
      arst_n <= 1'b1;
   endtask

   task automatic run_program(input string name);
      int n;
      int i;
      model_program();
      apply_reset();
      n = 0;
      while (!halted && n < HALT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!halted) begin
         $display("%s: halted never rose within %0d cycles", name, HALT_LIMIT);
         errors++;
      end
      // Quiet period with no write-backs after halt
      repeat (8) @(posedge clk);
      if (trace_q.size() < exp_q.size()) begin
         $display("%s: missing write-backs, %0d seen where %0d expected",
                  name, trace_q.size(), exp_q.size());
         errors++;
      end else if (trace_q.size() > exp_q.size()) begin
         $display("%s: extra write-backs, %0d seen where %0d expected",
                  name, trace_q.size(), exp_q.size());
         errors++;
      end
      for (i = 0; i < trace_q.size() && i < exp_q.size(); i++) begin
         check_trace(i, trace_q[i], exp_q[i]);
      end
   endtask

   task automatic test_arith_chain();
      logic [4:0] imm_a;
      logic [4:0] imm_b;
      logic [4:0] imm_c;
      imm_a = 5'($random(seed));
      imm_b = 5'($random(seed));
      imm_c = 5'($random(seed));
      fill_imem();
      imem[0] = encode_i(ADDI, 3'd0, 3'd1, imm_a);
      imem[1] = encode_i(ADDI, 3'd1, 3'd2, imm_b);
      imem[2] = encode_r(3'd1, 3'd2, 3'd3, ADD);
      imem[3] = encode_r(3'd3, 3'd1, 3'd4, SUB);
      imem[4] = encode_r(3'd4, 3'd3, 3'd5, XOR);
      imem[5] = encode_r(3'd5, 3'd4, 3'd6, AND);
      imem[6] = encode_i(ADDI, 3'd6, 3'd7, imm_c);
      imem[7] = encode_i(HALT, 3'd0, 3'd0, 5'd0);
      run_program("arith_chain");
      check_bit("err", err, 1'b0);
   endtask

   task automatic test_load_use();
      fill_imem();
      imem[0] = encode_i(ADDI, 3'd0, 3'd1, 5'd5);
      imem[1] = encode_i(ADDI, 3'd0, 3'd2, 5'h1d);
      imem[2] = encode_i(ST, 3'd1, 3'd2, 5'd2);
      imem[3] = encode_i(LD, 3'd1, 3'd3, 5'd2);
      imem[4] = encode_r(3'd3, 3'd1, 3'd4, ADD);
      imem[5] = encode_i(LD, 3'd1, 3'd5, 5'd2);
      // Loaded register used as rt
      imem[6] = encode_r(3'd1, 3'd5, 3'd6, XOR);
      imem[7] = encode_i(HALT, 3'd0, 3'd0, 5'd0);
      run_program("load_use");
   endtask

   task automatic test_branches();
      int i;
      fill_imem();
      imem[0] = encode_i(ADDI, 3'd0, 3'd1, 5'd4);
      imem[1] = encode_b(3'd1, 8'd3);
      imem[2] = encode_i(ADDI, 3'd1, 3'd2, 5'd1);
      imem[3] = encode_i(ADDI, 3'd0, 3'd3, 5'd0);
      imem[4] = encode_b(3'd3, 8'd2);
      imem[5] = encode_i(ADDI, 3'd0, 3'd4, 5'd7);
      imem[6] = encode_i(ADDI, 3'd0, 3'd5, 5'd9);
      imem[7] = encode_r(3'd1, 3'd2, 3'd6, ADD);
      imem[8] = encode_i(HALT, 3'd0, 3'd0, 5'd0);
      run_program("branches");
      for (i = 0; i < trace_q.size(); i++) begin
         if (trace_q[i].dest == 3'd4 || trace_q[i].dest == 3'd5) begin
            $display("branches: skipped instruction wrote r%0d", trace_q[i].dest);
            errors++;
         end
      end
   endtask

   task automatic test_halt();
      fill_imem();
      imem[0] = encode_i(ADDI, 3'd0, 3'd1, 5'd3);
      imem[1] = encode_i(ADDI, 3'd1, 3'd2, 5'd3);
      imem[2] = encode_i(HALT, 3'd0, 3'd0, 5'd0);
      imem[3] = encode_i(ADDI, 3'd0, 3'd3, 5'd1);
      imem[4] = encode_i(ADDI, 3'd0, 3'd4, 5'd2);
      run_program("halt");
      repeat (10) @(posedge clk);
      check_bit("halted", halted, 1'b1);
      if (trace_q.size() != exp_q.size()) begin
         $display("halt: write-back seen while the core was halted");
         errors++;
      end
   endtask

   task automatic test_illegal_opcode();
      fill_imem();
      imem[0] = encode_i(ADDI, 3'd0, 3'd1, 5'd6);
      // Opcode 11111 is undefined
      imem[1] = 16'hf800;
      imem[2] = encode_i(ADDI, 3'd1, 3'd2, 5'd1);
      imem[3] = encode_i(HALT, 3'd0, 3'd0, 5'd0);
      run_program("illegal_opcode");
      check_bit("err", err, 1'b1);
      repeat (4) @(posedge clk);
      check_bit("err", err, 1'b1);
      fill_imem();
      imem[0] = encode_i(ADDI, 3'd0, 3'd1, 5'd2);
      imem[1] = encode_r(3'd1, 3'd1, 3'd2, ADD);
      imem[2] = encode_i(HALT, 3'd0, 3'd0, 5'd0);
      run_program("after_reset");
      check_bit("err", err, 1'b0);
   endtask

   initial begin
      arst_n = 1'b0;
      seed   = 32'h055f16d4;
      errors = 0;
      checks = 0;
      fill_imem();
      test_arith_chain();
      test_load_use();
      test_branches();
      test_halt();
      test_illegal_opcode();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/pipe_reg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_core.sv
sim/cpu_core_properties.sv
sim/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds cpu_core_tb with Verilator, runs it and judges the result from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_core_tb -f src.f -o cpu_core_sim \
   > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/cpu_core_sim > sim.log 2>&1 || echo "Simulator exited with an error"
grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "No verdict found in sim.log"; exit 1; }
echo "Simulation passed"
